//--- renameStage.f
+incdir+test
verilog/archPkg.sv
verilog/renamePkg.sv
verilog/instDecode.sv
verilog/regStatusFile.sv
verilog/tagAllocator.sv
verilog/dispatchCtrl.sv
verilog/renameStage.sv
test/renameStageTb.sv

//--- test/renameTasks.svh
localparam logic [31:0] LfsrPoly = 32'hB4BC_D35C;
localparam int WaitLimit = 40;

logic [31:0] lfsrState = 32'd69;

// one galois step per bit taken
function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], lfsrState[0]};
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ LfsrPoly) : (lfsrState >> 1);
    end
    return value;
endfunction

function automatic renamePkg::resultBus_t makeBus(input archPkg::regName_t name,
        input renamePkg::tag_t tag, input archPkg::data_t data);
    renamePkg::resultBus_t bus;
    bus.en = 1'b1;
    bus.name = name;
    bus.tag = tag;
    bus.data = data;
    return bus;
endfunction

function automatic archPkg::instWord_t regWord(input archPkg::regName_t rd,
        input archPkg::regName_t rs1, input archPkg::regName_t rs2);
    archPkg::instWord_t word;
    word = '0;
    word.regView.rd = rd;
    word.regView.rs1 = rs1;
    word.regView.rs2 = rs2;
    return word;
endfunction

task automatic compareOperand(input string what, input renamePkg::operand_t got,
        input renamePkg::operand_t exp);
    checkCount++;
    if (got !== exp) begin
        valueErrors++;
        $display("error at %0t: %s got data %h tag %0d, expected data %h tag %0d",
                 $time, what, got.data, got.tag, exp.data, exp.tag);
    end
endtask

task automatic compareIssue(input string what, input renamePkg::issue_t got,
        input renamePkg::issue_t exp);
    checkCount++;
    if (got.destName !== exp.destName || got.destTag !== exp.destTag) begin
        valueErrors++;
        $display("error at %0t: %s dest r%0d tag %0d, expected r%0d tag %0d",
                 $time, what, got.destName, got.destTag, exp.destName, exp.destTag);
    end
    compareOperand({what, " opA"}, got.opA, exp.opA);
    compareOperand({what, " opB"}, got.opB, exp.opB);
endtask

task automatic compareBit(input string what, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
        valueErrors++;
        $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic waitIssue(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (issueValid !== 1'b1 && cycles < WaitLimit) begin
        @(negedge clk);
        cycles++;
    end
    if (issueValid !== 1'b1) begin
        otherErrors++;
        $display("timeout: %s was never issued", what);
    end
endtask

task automatic waitBusy(input logic want);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy !== want && cycles < WaitLimit) begin
        @(negedge clk);
        cycles++;
    end
    if (busy !== want) begin
        otherErrors++;
        $display("timeout: busy never went to %b", want);
    end
endtask

task automatic resetDut();
    arstN = 1'b0;
    instValid = 1'b0;
    instWord = '0;
    aluResult = '0;
    lsResult = '0;
    repeat (4) @(posedge clk);
    #Drive;
    arstN = 1'b1;
    resetShadow();
endtask

// bus writes only, nothing issues on this edge
task automatic pulseResult(input renamePkg::resultBus_t alu, input renamePkg::resultBus_t ls);
    @(posedge clk);
    #Drive;
    aluResult = alu;
    lsResult = ls;
    @(posedge clk);
    #Drive;
    aluResult = '0;
    lsResult = '0;
    applyEdge(alu, ls, '0);
endtask

// buses are live in the cycle the operands are read
task automatic runInst(input archPkg::instWord_t word, input archPkg::regName_t rd,
        input archPkg::regName_t srcA, input archPkg::regName_t srcB, input logic useImm,
        input archPkg::data_t immData, input renamePkg::resultBus_t alu,
        input renamePkg::resultBus_t ls, input string what);
    renamePkg::issue_t exp;
    @(posedge clk);
    #Drive;
    instValid = 1'b1;
    instWord = word;
    @(posedge clk);
    #Drive;
    instValid = 1'b0;
    aluResult = alu;
    lsResult = ls;
    exp = expectIssue(rd, srcA, srcB, useImm, immData, alu, ls);
    @(posedge clk);
    #Drive;
    aluResult = '0;
    lsResult = '0;
    applyEdge(alu, ls, rd);
    waitIssue(what);
    compareIssue(what, issue, exp);
endtask

task automatic runReg(input archPkg::regName_t rd, input archPkg::regName_t rs1,
        input archPkg::regName_t rs2, input renamePkg::resultBus_t alu,
        input renamePkg::resultBus_t ls, input string what);
    runInst(regWord(rd, rs1, rs2), rd, rs1, rs2, 1'b0, '0, alu, ls, what);
endtask

task automatic runImm(input archPkg::regName_t rd, input archPkg::regName_t rs1,
        input logic [15:0] imm, input string what);
    archPkg::instWord_t word;
    word = '0;
    word.immView.form = archPkg::FormImm;
    word.immView.rd = rd;
    word.immView.rs1 = rs1;
    word.immView.imm = imm;
    runInst(word, rd, rs1, '0, 1'b1, {{16{imm[15]}}, imm}, '0, '0, what);
endtask

//--- test/renameStageTb.sv
module renameStageTb;

    localparam int TagCount = 15;
    localparam int Drive = 2;

    logic clk = 1'b0;
    logic arstN;
    logic instValid;
    archPkg::instWord_t instWord;
    renamePkg::resultBus_t aluResult;
    renamePkg::resultBus_t lsResult;
    logic busy;
    logic issueValid;
    renamePkg::issue_t issue;

    int checkCount = 0;
    int valueErrors = 0;
    int otherErrors = 0;

    // shadow of register values, producer tags and the tag counter
    archPkg::data_t shadowVal [archPkg::RegCount];
    renamePkg::tag_t shadowTag [archPkg::RegCount];
    renamePkg::tag_t shadowNext;

    always #4 clk = ~clk;

    renameStage #(
        .TagCount(TagCount)
    ) dut_i (
        .clk(clk),
        .arstN(arstN),
        .instValid(instValid),
        .instWord(instWord),
        .aluResult(aluResult),
        .lsResult(lsResult),
        .busy(busy),
        .issueValid(issueValid),
        .issue(issue)
    );

    function automatic void resetShadow();
        for (int i = 0; i < archPkg::RegCount; i++) begin
            shadowVal[i] = '0;
            shadowTag[i] = '0;
        end
        shadowNext = renamePkg::tag_t'(1);
    endfunction

    // what a reader sees, with this cycle's bus writes folded in
    function automatic renamePkg::operand_t expectOperand(input archPkg::regName_t name,
            input renamePkg::resultBus_t alu, input renamePkg::resultBus_t ls);
        renamePkg::operand_t op;
        logic aluHit;
        logic lsHit;
        aluHit = alu.en && alu.name == name;
        lsHit = ls.en && ls.name == name;
        op.data = aluHit ? alu.data : (lsHit ? ls.data : shadowVal[name]);
        op.tag = shadowTag[name];
        if ((aluHit && alu.tag == op.tag) || (lsHit && ls.tag == op.tag)) begin
            op.tag = '0;
        end
        if (name == '0) begin
            op = '0;
        end
        return op;
    endfunction

    function automatic renamePkg::issue_t expectIssue(input archPkg::regName_t rd,
            input archPkg::regName_t srcA, input archPkg::regName_t srcB, input logic useImm,
            input archPkg::data_t immData, input renamePkg::resultBus_t alu,
            input renamePkg::resultBus_t ls);
        renamePkg::issue_t exp;
        exp.destName = rd;
        exp.destTag = (rd == '0) ? '0 : shadowNext;
        exp.opA = expectOperand(srcA, alu, ls);
        exp.opB = expectOperand(srcB, alu, ls);
        if (useImm) begin
            exp.opB.data = immData;
            exp.opB.tag = '0;
        end
        return exp;
    endfunction

    // one clock edge: bus writes, then the rename of rd
    function automatic void applyEdge(input renamePkg::resultBus_t alu,
            input renamePkg::resultBus_t ls, input archPkg::regName_t rd);
        logic aluClear;
        logic lsClear;
        aluClear = alu.en && shadowTag[alu.name] == alu.tag;
        lsClear = ls.en && shadowTag[ls.name] == ls.tag;
        if (ls.en && ls.name != '0) begin
            shadowVal[ls.name] = ls.data;
        end
        if (alu.en && alu.name != '0) begin
            shadowVal[alu.name] = alu.data;
        end
        if (lsClear) begin
            shadowTag[ls.name] = '0;
        end
        if (aluClear) begin
            shadowTag[alu.name] = '0;
        end
        if (rd != '0) begin
            shadowTag[rd] = shadowNext;
            shadowNext = (int'(shadowNext) == TagCount) ? renamePkg::tag_t'(1) : shadowNext + 1'b1;
        end
    endfunction

    `include "renameTasks.svh"

    task automatic testResetState();
        archPkg::regName_t srcA;
        archPkg::regName_t srcB;
        for (int i = 0; i < 4; i++) begin
            srcA = archPkg::regName_t'(randBits(5));
            srcB = archPkg::regName_t'(randBits(5));
            runReg('0, srcA, srcB, '0, '0, "read after reset");
        end
        runReg('0, '0, '0, '0, '0, "r0 only");
    endtask

    task automatic testRename();
        runReg(5'd7, 5'd3, 5'd4, '0, '0, "rename r7");
        pulseResult(makeBus(5'd7, shadowTag[7], randBits(32)), '0);
        runReg(5'd7, 5'd0, 5'd0, '0, '0, "rename r7 again");
        runReg(5'd9, 5'd7, 5'd7, '0, '0, "read renamed r7");
    endtask

    task automatic testResultBus();
        renamePkg::tag_t oldTag;
        pulseResult('0, makeBus(5'd9, shadowTag[9], randBits(32)));
        runReg(5'd10, 5'd9, 5'd7, '0, '0, "matching write");
        oldTag = shadowTag[7];
        runReg(5'd7, 5'd0, 5'd0, '0, '0, "rename r7 third");
        pulseResult(makeBus(5'd7, oldTag, randBits(32)), '0);
        runReg(5'd11, 5'd7, 5'd0, '0, '0, "stale tag write");
        runReg(5'd12, 5'd7, 5'd10, makeBus(5'd7, shadowTag[7], randBits(32)),
               makeBus(5'd10, shadowTag[10], randBits(32)), "bypass");
        // new tag must survive a clear of the same register
        runReg(5'd11, 5'd11, 5'd0, makeBus(5'd11, shadowTag[11], randBits(32)), '0,
               "rename over clear");
        runReg(5'd13, 5'd11, 5'd12, '0, '0, "read after tie");
    endtask

    task automatic testImmediate();
        logic [15:0] imm;
        imm = 16'(randBits(16));
        runImm(5'd14, 5'd13, imm | 16'h8000, "negative immediate");
        runImm(5'd15, 5'd0, imm & 16'h7fff, "positive immediate");
    endtask

    task automatic testStall();
        renamePkg::resultBus_t freeBus;
        renamePkg::issue_t exp;
        @(posedge clk);
        #Drive;
        resetDut();
        for (int i = 1; i <= TagCount; i++) begin
            runReg(archPkg::regName_t'(i), 5'd0, 5'd0, '0, '0, "fill tags");
        end
        @(posedge clk);
        #Drive;
        instValid = 1'b1;
        instWord = regWord(5'd20, 5'd1, 5'd2);
        @(posedge clk);
        #Drive;
        instValid = 1'b0;
        waitBusy(1'b1);
        repeat (3) begin
            @(negedge clk);
            compareBit("issueValid while full", issueValid, 1'b0);
        end
        freeBus = makeBus(5'd1, shadowTag[1], randBits(32));
        pulseResult('0, freeBus);
        exp = expectIssue(5'd20, 5'd1, 5'd2, 1'b0, '0, '0, '0);
        applyEdge('0, '0, 5'd20);
        waitIssue("released instruction");
        compareIssue("released instruction", issue, exp);
        compareBit("wrapped tag is 1", issue.destTag == renamePkg::tag_t'(1), 1'b1);
        waitBusy(1'b0);
    endtask

    initial begin
        resetDut();
        testResetState();
        testRename();
        testResultBus();
        testImmediate();
        testStall();
        $display("checks %0d, value errors %0d, other failures %0d",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/archPkg.sv
package archPkg;

    localparam int NameWidth = 5;
    localparam int DataWidth = 32;
    localparam int InstWidth = 32;
    localparam int ImmWidth = 16;
    localparam int RegCount = 2 ** NameWidth;

    // form bit value selecting the immediate view
    localparam logic FormImm = 1'b1;

    typedef logic [NameWidth-1:0] regName_t;
    typedef logic [DataWidth-1:0] data_t;

    typedef struct packed {
        logic form;
        regName_t rd;
        regName_t rs1;
        regName_t rs2;
        logic [InstWidth-16-1:0] spare;
    } regForm_t;

    // pad sits where rs2 lives in the register form
    typedef struct packed {
        logic form;
        regName_t rd;
        regName_t rs1;
        logic [NameWidth-1:0] pad;
        logic signed [ImmWidth-1:0] imm;
    } immForm_t;

    typedef union packed {
        regForm_t regView;
        immForm_t immView;
    } instWord_t;

endpackage

//--- verilog/dispatchCtrl.sv
module dispatchCtrl #(
    parameter int TagCount = 15
) (
    input logic clk,
    input logic arstN,
    input logic instValid,
    input archPkg::regName_t srcNameA,
    input archPkg::regName_t srcNameB,
    input archPkg::regName_t destName,
    input logic useImm,
    input renamePkg::operand_t immOperand,
    input logic full,
    input renamePkg::tag_t nextTag,
    input renamePkg::operand_t readA,
    input renamePkg::operand_t readB,
    output archPkg::regName_t readNameA,
    output archPkg::regName_t readNameB,
    output archPkg::regName_t renameName,
    output logic renameEn,
    output logic allocate,
    output logic busy,
    output logic issueValid,
    output renamePkg::issue_t issue
);

    typedef struct packed {
        archPkg::regName_t srcNameA;
        archPkg::regName_t srcNameB;
        archPkg::regName_t destName;
        logic useImm;
        renamePkg::operand_t immOperand;
    } held_t;

    // stall means an instruction is held until a tag is free
    typedef enum logic {
        Idle,
        Stall
    } state_t;

    state_t state;
    state_t stateNext;
    held_t held;
    logic accept;
    logic issueNow;
    logic destLive;

    assign issueNow = (state == Stall) && !full;
    assign busy = (state == Stall) && full;
    assign accept = instValid && !busy;

    // r0 destination takes no tag
    assign destLive = (held.destName != '0);

    assign readNameA = held.srcNameA;
    assign readNameB = held.srcNameB;
    assign renameName = held.destName;
    assign renameEn = issueNow && destLive;
    assign allocate = issueNow && destLive;

    always_comb begin
        stateNext = state;
        if (accept) begin
            stateNext = Stall;
        end else if (issueNow) begin
            stateNext = Idle;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Idle;
            issueValid <= 1'b0;
        end else begin
            state <= stateNext;
            issueValid <= issueNow;
        end
    end

    // a new capture may overwrite the entry issuing on the same edge
    always_ff @(posedge clk) begin
        if (accept) begin
            held.srcNameA <= srcNameA;
            held.srcNameB <= srcNameB;
            held.destName <= destName;
            held.useImm <= useImm;
            held.immOperand <= immOperand;
        end
    end

    always_ff @(posedge clk) begin
        if (issueNow) begin
            issue.destName <= held.destName;
            issue.destTag <= destLive ? nextTag : '0;
            issue.opA <= readA;
            issue.opB <= held.useImm ? held.immOperand : readB;
        end
    end

    noInstWhileBusy: assert property (
        @(posedge clk) disable iff (!arstN)
        busy |-> !instValid
    ) else $error("instValid raised while busy");

    allocateValidTag: assert property (
        @(posedge clk) disable iff (!arstN)
        allocate |-> !full && nextTag != '0 && nextTag <= TagCount
    ) else $error("tag allocated while full or out of range");

endmodule

//--- verilog/instDecode.sv
module instDecode (
    input archPkg::instWord_t instWord,
    output archPkg::regName_t srcNameA,
    output archPkg::regName_t srcNameB,
    output archPkg::regName_t destName,
    output logic useImm,
    output renamePkg::operand_t immOperand
);

    localparam int ExtWidth = archPkg::DataWidth - archPkg::ImmWidth;

    always_comb begin
        useImm = (instWord.regView.form == archPkg::FormImm);
        // rd and rs1 sit at the same bits in both views
        destName = instWord.regView.rd;
        srcNameA = instWord.regView.rs1;
        if (useImm) begin
            // second source is the immediate, read r0 instead
            srcNameB = '0;
            immOperand.data = {
                {ExtWidth{instWord.immView.imm[archPkg::ImmWidth-1]}},
                instWord.immView.imm
            };
            immOperand.tag = '0;
        end else begin
            srcNameB = instWord.regView.rs2;
            immOperand = '0;
        end
    end

endmodule

//--- verilog/regStatusFile.sv
module regStatusFile (
    input logic clk,
    input logic arstN,
    input renamePkg::resultBus_t aluResult,
    input renamePkg::resultBus_t lsResult,
    input archPkg::regName_t readNameA,
    input archPkg::regName_t readNameB,
    input logic renameEn,
    input archPkg::regName_t renameName,
    input renamePkg::tag_t renameTag,
    output renamePkg::operand_t readA,
    output renamePkg::operand_t readB
);

    archPkg::data_t values [archPkg::RegCount];
    renamePkg::tag_t tags [archPkg::RegCount];

    // bus carries the tag the register still waits on
    logic aluClear;
    logic lsClear;

    assign aluClear = aluResult.en && (aluResult.tag == tags[aluResult.name]);
    assign lsClear = lsResult.en && (lsResult.tag == tags[lsResult.name]);

    // state as it will look after this edge, minus the rename
    function automatic renamePkg::operand_t readPort(input archPkg::regName_t name);
        renamePkg::operand_t op;
        op.data = values[name];
        op.tag = tags[name];
        // alu has priority, so it goes last
        if (lsResult.en && lsResult.name == name) begin
            op.data = lsResult.data;
        end
        if (aluResult.en && aluResult.name == name) begin
            op.data = aluResult.data;
        end
        if ((aluClear && aluResult.name == name) || (lsClear && lsResult.name == name)) begin
            op.tag = '0;
        end
        // hard zero register
        if (name == '0) begin
            op = '0;
        end
        return op;
    endfunction

    always_comb begin
        readA = readPort(readNameA);
    end

    always_comb begin
        readB = readPort(readNameB);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < archPkg::RegCount; i++) begin
                values[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            // value follows every bus write, alu wins a same-register tie
            if (lsResult.en && lsResult.name != '0) begin
                values[lsResult.name] <= lsResult.data;
            end
            if (aluResult.en && aluResult.name != '0) begin
                values[aluResult.name] <= aluResult.data;
            end
            if (lsClear) begin
                tags[lsResult.name] <= '0;
            end
            if (aluClear) begin
                tags[aluResult.name] <= '0;
            end
            // rename last so a new tag overrides a clear
            if (renameEn && renameName != '0) begin
                tags[renameName] <= renameTag;
            end
        end
    end

endmodule

//--- verilog/renamePkg.sv
package renamePkg;

    localparam int TagWidth = 4;

    // zero means the value is ready
    typedef logic [TagWidth-1:0] tag_t;

    // one write from a result bus
    typedef struct packed {
        logic en;
        archPkg::regName_t name;
        tag_t tag;
        archPkg::data_t data;
    } resultBus_t;

    // ready value, or the producer tag to wait on
    typedef struct packed {
        archPkg::data_t data;
        tag_t tag;
    } operand_t;

    typedef struct packed {
        archPkg::regName_t destName;
        tag_t destTag;
        operand_t opA;
        operand_t opB;
    } issue_t;

endpackage

//--- verilog/renameStage.sv
module renameStage #(
    parameter int TagCount = 15
) (
    input logic clk,
    input logic arstN,
    input logic instValid,
    input archPkg::instWord_t instWord,
    input renamePkg::resultBus_t aluResult,
    input renamePkg::resultBus_t lsResult,
    output logic busy,
    output logic issueValid,
    output renamePkg::issue_t issue
);

    archPkg::regName_t srcNameA;
    archPkg::regName_t srcNameB;
    archPkg::regName_t destName;
    logic useImm;
    renamePkg::operand_t immOperand;

    archPkg::regName_t readNameA;
    archPkg::regName_t readNameB;
    archPkg::regName_t renameName;
    logic renameEn;
    logic allocate;

    renamePkg::tag_t nextTag;
    logic full;
    renamePkg::operand_t readA;
    renamePkg::operand_t readB;

    instDecode decode_i (
        .instWord(instWord),
        .srcNameA(srcNameA),
        .srcNameB(srcNameB),
        .destName(destName),
        .useImm(useImm),
        .immOperand(immOperand)
    );

    dispatchCtrl #(
        .TagCount(TagCount)
    ) dispatch_i (
        .clk(clk),
        .arstN(arstN),
        .instValid(instValid),
        .srcNameA(srcNameA),
        .srcNameB(srcNameB),
        .destName(destName),
        .useImm(useImm),
        .immOperand(immOperand),
        .full(full),
        .nextTag(nextTag),
        .readA(readA),
        .readB(readB),
        .readNameA(readNameA),
        .readNameB(readNameB),
        .renameName(renameName),
        .renameEn(renameEn),
        .allocate(allocate),
        .busy(busy),
        .issueValid(issueValid),
        .issue(issue)
    );

    // every bus write retires one tag
    tagAllocator #(
        .TagCount(TagCount)
    ) alloc_i (
        .clk(clk),
        .arstN(arstN),
        .allocate(allocate),
        .aluRetire(aluResult.en),
        .lsRetire(lsResult.en),
        .nextTag(nextTag),
        .full(full)
    );

    regStatusFile regFile_i (
        .clk(clk),
        .arstN(arstN),
        .aluResult(aluResult),
        .lsResult(lsResult),
        .readNameA(readNameA),
        .readNameB(readNameB),
        .renameEn(renameEn),
        .renameName(renameName),
        .renameTag(nextTag),
        .readA(readA),
        .readB(readB)
    );

endmodule

//--- verilog/tagAllocator.sv
module tagAllocator #(
    parameter int TagCount = 15
) (
    input logic clk,
    input logic arstN,
    input logic allocate,
    input logic aluRetire,
    input logic lsRetire,
    output renamePkg::tag_t nextTag,
    output logic full
);

    localparam int CountWidth = $clog2(TagCount + 1);

    logic [CountWidth-1:0] inFlight;

    if (TagCount < 1 || TagCount >= 2 ** renamePkg::TagWidth) begin : gBadTagCount
        $error("TagCount must leave tag zero free");
    end

    assign full = (inFlight == CountWidth'(TagCount));

    // rolling counter, never hands out zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            nextTag <= renamePkg::tag_t'(1);
        end else if (allocate) begin
            if (nextTag == renamePkg::tag_t'(TagCount)) begin
                nextTag <= renamePkg::tag_t'(1);
            end else begin
                nextTag <= nextTag + 1'b1;
            end
        end
    end

    // each result pulse returns exactly one tag
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inFlight <= '0;
        end else begin
            inFlight <= inFlight + CountWidth'(allocate)
                        - CountWidth'(aluRetire) - CountWidth'(lsRetire);
        end
    end

    countNoUnderflow: assert property (
        @(posedge clk) disable iff (!arstN)
        int'(aluRetire) + int'(lsRetire) <= int'(inFlight) + int'(allocate)
    ) else $error("more results returned than tags in flight");

endmodule
